// ==== common/forth_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared definitions for the serial console Forth machine
// Cell and address widths, the opcode set, the token that
// travels from the outer to the inner interpreter, and the
// contents of the boot ROM and the linked dictionary
// Modules pull these in with a wildcard import
////////////////////////////////////////////////////////////
package forth_pkg;

	typedef logic [31:0] cell_t;
	typedef logic [5:0]  code_addr_t;
	typedef logic [4:0]  dict_addr_t;
	typedef logic [7:0]  char_t;

	// Opcode sits in the low 16 bits of a ROM cell
	typedef enum logic [15:0] {
		op_execute, op_lit, op_number, op_plus, op_minus, op_dup, op_drop,
		op_equal, op_zero_equal, op_branch, op_zero_branch, op_emit, op_io_led
	} op_e;

	// Number tokens carry their own value
	typedef struct packed {
		code_addr_t xt;
		cell_t      value;
	} token_t;

	localparam int BOOT_DEPTH = 48;
	localparam int DICT_DEPTH = 21;
	localparam int NAME_CELLS_MAX = 2;
	localparam code_addr_t XT_ERROR = 6'd1;
	localparam code_addr_t XT_NUMBER = 6'd21;

	typedef cell_t boot_rom_t [BOOT_DEPTH];
	typedef cell_t dict_rom_t [DICT_DEPTH];

	// Every word ends by branching back to the execute loop at 0
	function automatic boot_rom_t boot_rom_init();
		boot_rom_t rom;
		rom = '{
			0: cell_t'(op_execute),
			// Error word prints a question mark
			1: cell_t'(op_lit), 2: cell_t'("?"), 3: cell_t'(op_emit),
			4: cell_t'(op_branch), 5: 0,
			// red, green, blue
			6: cell_t'(op_lit), 7: 4, 8: cell_t'(op_io_led), 9: cell_t'(op_branch), 10: 0,
			11: cell_t'(op_lit), 12: 1, 13: cell_t'(op_io_led), 14: cell_t'(op_branch), 15: 0,
			16: cell_t'(op_lit), 17: 2, 18: cell_t'(op_io_led), 19: cell_t'(op_branch), 20: 0,
			// Digit token and led
			21: cell_t'(op_number), 22: cell_t'(op_branch), 23: 0,
			24: cell_t'(op_io_led), 25: cell_t'(op_branch), 26: 0,
			// Dot prints a space and then the digit
			39: cell_t'(op_lit), 40: cell_t'(" "), 41: cell_t'(op_emit),
			42: cell_t'(op_lit), 43: cell_t'("0"), 44: cell_t'(op_plus),
			45: cell_t'(op_emit), 46: cell_t'(op_branch), 47: 0,
			default: '0
		};
		return rom;
	endfunction

	// Entry is link, name cells, xt; a zero link ends the chain
	function automatic dict_rom_t dict_init();
		dict_rom_t d;
		d = '{
			0: 3, 1: {8'd1, "red"}, 2: 6,
			3: 7, 4: {8'd2, "gre"}, 5: {"en", 16'h0}, 6: 11,
			7: 11, 8: {8'd2, "blu"}, 9: {"e", 24'h0}, 10: 16,
			11: 14, 12: {8'd1, "led"}, 13: 24,
			14: 0, 15: {8'd1, ".", 16'h0}, 16: 39,
			default: '0
		};
		return d;
	endfunction

endpackage

// ==== src/uart_rx.sv ====
////////////////////////////////////////////////////////////
// Serial receiver for the console input, 8N1
// Samples each bit at mid-period and holds the byte with
// rx_valid until the outer interpreter acknowledges it
////////////////////////////////////////////////////////////
module uart_rx import forth_pkg::*; #(
	parameter int BIT_CLKS = 625
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	input  logic  rx_ack,
	output char_t rx_byte,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(BIT_CLKS);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

	rx_state_e        state;
	logic [1:0]       rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	char_t            shift;
	logic             half_tick;
	logic             bit_tick;

	assign half_tick = clk_cnt == CNT_W'(BIT_CLKS / 2 - 1);
	assign bit_tick = clk_cnt == CNT_W'(BIT_CLKS - 1);

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_idle;
			rx_sync <= 2'b11;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			// Two-flop synchronizer on the line
			rx_sync <= {rx_sync[0], rx};
			if (rx_ack)
				rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					// Held byte blocks a new frame
					if (!rx_valid && !rx_sync[1])
						state <= st_start;
				end
				st_start: begin
					if (half_tick) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// Glitch check at middle of start bit
						state <= rx_sync[1] ? st_idle : st_data;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				st_data: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						// LSB first
						shift <= {rx_sync[1], shift[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= st_stop;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						state <= st_idle;
						// Framing error drops the byte
						if (rx_sync[1]) begin
							rx_valid <= 1'b1;
							rx_byte <= shift;
						end
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== src/uart_tx.sv ====
////////////////////////////////////////////////////////////
// Serial transmitter for the console output, 8N1
// A one-cycle tx_start while idle latches the byte
// tx_busy covers start, data and stop bits
////////////////////////////////////////////////////////////
module uart_tx import forth_pkg::*; #(
	parameter int BIT_CLKS = 625
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  tx_start,
	input  char_t tx_byte,
	output logic  tx,
	output logic  tx_busy
);

	localparam int CNT_W = $clog2(BIT_CLKS);

	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	// Data bits then the stop bit
	logic [8:0]       shift;

	always_ff @(posedge clk) begin
		if (!reset) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// Start bit goes out on the next cycle
				tx <= 1'b0;
				shift <= {1'b1, tx_byte};
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == CNT_W'(BIT_CLKS - 1)) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				// Stop bit has run its full period
				tx_busy <= 1'b0;
			end else begin
				tx <= shift[0];
				shift <= {1'b1, shift[8:1]};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else
			clk_cnt <= clk_cnt + 1'b1;
	end

endmodule

// ==== outer_interp/outer_interp.sv ====
////////////////////////////////////////////////////////////
// Outer interpreter
// Packs typed characters into name cells, searches the
// linked dictionary on a space, CR or LF and pushes one
// token per word into the token FIFO
// Unknown single digits become number tokens
////////////////////////////////////////////////////////////
module outer_interp import forth_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  char_t  rx_byte,
	input  logic   rx_valid,
	output logic   rx_ack,
	input  logic   full,
	output token_t wr_token,
	output logic   push
);

	localparam dict_rom_t DICT = dict_init();
	// First cell gives its top byte to the count
	localparam int NAME_CHARS = NAME_CELLS_MAX * 4 - 1;

	typedef enum logic [2:0] {st_idle, st_link, st_cmp, st_xt, st_push} parse_state_e;

	parse_state_e state;
	cell_t        word_cells [NAME_CELLS_MAX];
	logic [3:0]   n_chars;
	logic         too_long;
	dict_addr_t   wp;
	dict_addr_t   link;
	logic [1:0]   cell_idx;
	logic [1:0]   n_cells;
	logic [2:0]   slot;
	logic         is_delim;
	char_t        first_char;
	cell_t        want;

	assign is_delim = rx_byte == " " || rx_byte == 8'd13 || rx_byte == 8'd10;
	assign n_cells = 2'(n_chars / 4) + 2'd1;
	// Byte slot of the next char, slot 0 is the count
	assign slot = 3'(n_chars + 4'd1);
	assign first_char = word_cells[0][23:16];
	// Count is merged into cell 0 only at compare time
	assign want = (cell_idx == 2'd0) ? {6'b0, n_cells, word_cells[0][23:0]}
		: word_cells[cell_idx[0]];

	assign push = state == st_push && !full;
	// Plain chars and empty words are taken at once
	// A delimiter stays held until its token is pushed
	assign rx_ack = push || (state == st_idle && rx_valid && (!is_delim || n_chars == 4'd0));

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_idle;
			n_chars <= '0;
			too_long <= 1'b0;
			wp <= '0;
			link <= '0;
			cell_idx <= '0;
			word_cells <= '{default: '0};
		end else begin
			case (state)
				st_idle: begin
					if (rx_valid) begin
						if (!is_delim) begin
							if (n_chars == 4'(NAME_CHARS))
								too_long <= 1'b1;
							else begin
								word_cells[slot[2]][8 * (3 - slot[1:0]) +: 8] <= rx_byte;
								n_chars <= n_chars + 1'b1;
							end
						end else if (too_long) begin
							// Overlong word never matches
							wr_token <= '{xt: XT_ERROR, value: '0};
							state <= st_push;
						end else if (n_chars != 4'd0) begin
							wp <= '0;
							state <= st_link;
						end
					end
				end
				st_link: begin
					link <= dict_addr_t'(DICT[wp]);
					wp <= wp + 1'b1;
					cell_idx <= '0;
					state <= st_cmp;
				end
				st_cmp: begin
					if (cell_idx == n_cells)
						state <= st_xt;
					else if (DICT[wp] == want) begin
						wp <= wp + 1'b1;
						cell_idx <= cell_idx + 1'b1;
					end else if (link != '0) begin
						// Next entry in the chain
						wp <= link;
						state <= st_link;
					end else begin
						// End of dictionary, try a digit
						if (n_chars == 4'd1 && first_char inside {["0":"9"]})
							wr_token <= '{xt: XT_NUMBER, value: cell_t'(first_char - "0")};
						else
							wr_token <= '{xt: XT_ERROR, value: '0};
						state <= st_push;
					end
				end
				st_xt: begin
					wr_token <= '{xt: code_addr_t'(DICT[wp]), value: '0};
					state <= st_push;
				end
				default: begin
					// Wait here while the FIFO is full
					if (!full) begin
						state <= st_idle;
						n_chars <= '0;
						too_long <= 1'b0;
						word_cells <= '{default: '0};
					end
				end
			endcase
		end
	end

endmodule

// ==== src/token_fifo.sv ====
////////////////////////////////////////////////////////////
// Circular token FIFO between the two interpreters
// rd_token always shows the head entry
// Push and pop may happen in the same cycle
////////////////////////////////////////////////////////////
module token_fifo import forth_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   push,
	input  token_t wr_token,
	output logic   full,
	input  logic   pop,
	output token_t rd_token,
	output logic   empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	token_t           mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign full = count == CNT_W'(FIFO_DEPTH);
	assign empty = count == '0;
	assign rd_token = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_token;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== inner_interp/inner_interp.sv ====
////////////////////////////////////////////////////////////
// Inner interpreter, the fetch/execute unit
// Runs boot ROM code one cell per clock, keeps a circular
// data stack, drives the LEDs and hands bytes to the UART
// Address 0 pops the next token and jumps to its code
////////////////////////////////////////////////////////////
module inner_interp import forth_pkg::*; #(
	parameter int STACK_DEPTH = 16
) (
	input  logic   clk,
	input  logic   reset,
	input  token_t rd_token,
	input  logic   empty,
	output logic   pop,
	output char_t  tx_byte,
	output logic   tx_start,
	input  logic   tx_busy,
	output logic   led_g,
	output logic   led_b,
	output logic   led_r
);

	localparam boot_rom_t ROM = boot_rom_init();
	localparam int SP_W = $clog2(STACK_DEPTH);

	code_addr_t      pc;
	cell_t           cur;
	cell_t           operand;
	op_e             op;
	cell_t           stack [STACK_DEPTH];
	logic [SP_W-1:0] dp;
	cell_t           tos;
	cell_t           nos;
	cell_t           tok_value;
	logic            emit_wait;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	assign cur = ROM[pc];
	// Inline operand of lit and branch
	assign operand = ROM[pc + 6'd1];
	assign op = op_e'(cur[15:0]);
	// dp points at the top of stack
	assign tos = stack[dp];
	assign nos = stack[dp - 1'b1];

	assign pop = op == op_execute && !empty;
	assign tx_start = op == op_emit && !emit_wait && !tx_busy;
	assign tx_byte = tos[7:0];

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			dp <= '0;
			emit_wait <= 1'b0;
			led_g <= 1'b1;
			led_b <= 1'b1;
			led_r <= 1'b1;
		end else begin
			case (op)
				op_execute: begin
					// Stall until a token arrives
					if (!empty) begin
						pc <= rd_token.xt;
						tok_value <= rd_token.value;
					end
				end
				op_lit: begin
					stack[dp + 1'b1] <= operand;
					dp <= dp + 1'b1;
					pc <= pc + 6'd2;
				end
				op_number: begin
					stack[dp + 1'b1] <= tok_value;
					dp <= dp + 1'b1;
					pc <= pc + 6'd1;
				end
				op_plus: begin
					stack[dp - 1'b1] <= nos + tos;
					dp <= dp - 1'b1;
					pc <= pc + 6'd1;
				end
				op_minus: begin
					stack[dp - 1'b1] <= nos - tos;
					dp <= dp - 1'b1;
					pc <= pc + 6'd1;
				end
				op_dup: begin
					stack[dp + 1'b1] <= tos;
					dp <= dp + 1'b1;
					pc <= pc + 6'd1;
				end
				op_drop: begin
					dp <= dp - 1'b1;
					pc <= pc + 6'd1;
				end
				op_equal: begin
					// True is all ones
					stack[dp - 1'b1] <= (nos == tos) ? '1 : '0;
					dp <= dp - 1'b1;
					pc <= pc + 6'd1;
				end
				op_zero_equal: begin
					stack[dp] <= (tos == '0) ? '1 : '0;
					pc <= pc + 6'd1;
				end
				op_branch:
					pc <= code_addr_t'(operand);
				op_zero_branch: begin
					dp <= dp - 1'b1;
					pc <= (tos == '0) ? code_addr_t'(operand) : pc + 6'd2;
				end
				op_emit: begin
					// Send once idle, then wait out the frame
					if (!emit_wait) begin
						if (!tx_busy) begin
							emit_wait <= 1'b1;
							dp <= dp - 1'b1;
						end
					end else if (!tx_busy) begin
						emit_wait <= 1'b0;
						pc <= pc + 6'd1;
					end
				end
				op_io_led: begin
					// Set bit lights the LED
					led_g <= !tos[0];
					led_b <= !tos[1];
					led_r <= !tos[2];
					dp <= dp - 1'b1;
					pc <= pc + 6'd1;
				end
				default:
					pc <= pc + 6'd1;
			endcase
		end
	end

endmodule

// ==== src/forth_top.sv ====
////////////////////////////////////////////////////////////
// Top level of the serial console Forth machine
// rx -> uart_rx -> outer_interp -> token_fifo
//    -> inner_interp -> uart_tx -> tx, plus three LEDs
// BIT_CLKS sets the baud rate from the system clock
////////////////////////////////////////////////////////////
module forth_top import forth_pkg::*; #(
	parameter int BIT_CLKS = 625,
	parameter int FIFO_DEPTH = 8,
	parameter int STACK_DEPTH = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_g,
	output logic led_b,
	output logic led_r
);

	// Receive side
	char_t  rx_byte;
	logic   rx_valid;
	logic   rx_ack;
	// Token path
	token_t wr_token;
	token_t rd_token;
	logic   push;
	logic   full;
	logic   pop;
	logic   empty;
	// Transmit side
	char_t  tx_byte;
	logic   tx_start;
	logic   tx_busy;

	uart_rx #(.BIT_CLKS(BIT_CLKS)) u_uart_rx (
		.clk, .reset, .rx, .rx_ack, .rx_byte, .rx_valid
	);

	outer_interp u_outer_interp (
		.clk, .reset, .rx_byte, .rx_valid, .rx_ack, .full, .wr_token, .push
	);

	token_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_token_fifo (
		.clk, .reset, .push, .wr_token, .full, .pop, .rd_token, .empty
	);

	inner_interp #(.STACK_DEPTH(STACK_DEPTH)) u_inner_interp (
		.clk, .reset, .rd_token, .empty, .pop, .tx_byte, .tx_start, .tx_busy,
		.led_g, .led_b, .led_r
	);

	uart_tx #(.BIT_CLKS(BIT_CLKS)) u_uart_tx (
		.clk, .reset, .tx_start, .tx_byte, .tx, .tx_busy
	);

endmodule

// ==== tests/forth_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the serial console Forth machine
// Types lines into rx, decodes whatever comes back on tx
// and checks the text and the LEDs for each table entry
// Digits are picked by an LCG with a fixed seed
////////////////////////////////////////////////////////////
module forth_tb;

	localparam int BIT_CLKS = 16;
	localparam int CLK_PERIOD = 20;
	// tx must stay quiet this long before a check
	localparam int IDLE_BITS = 40;

	logic clk = 1'b0;
	logic reset;
	logic rx;
	logic tx;
	logic led_g;
	logic led_b;
	logic led_r;

	// Test table, LED triple is {r, b, g}, 1 means off
	string      line_tab[$];
	string      text_tab[$];
	logic [2:0] led_tab[$];

	string       rx_text = "";
	logic        dec_busy = 1'b0;
	int          err_cnt = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int unsigned lcg_state = 32'd70805;
	longint      wd_time = 0;

	forth_top #(.BIT_CLKS(BIT_CLKS)) UUT (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx),
		.led_g(led_g), .led_b(led_b), .led_r(led_r)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic int pick_digit();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'((lcg_state >> 16) % 32'd10);
	endfunction

	// ASCII digit for a value 0 to 9
	function automatic logic [7:0] digit_char(input int d);
		return 8'h30 + 8'(d);
	endfunction

	task automatic add_entry(input string line, input string text, input logic [2:0] leds);
		line_tab.push_back(line);
		text_tab.push_back(text);
		led_tab.push_back(leds);
	endtask

	// 8N1 frame, then one idle frame
	task automatic send_byte(input logic [7:0] ch);
		logic [9:0] frame;
		frame = {1'b1, ch, 1'b0};
		for (int b = 0; b < 10; b++) begin
			@(posedge clk);
			rx <= frame[b];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		repeat (10 * BIT_CLKS) @(posedge clk);
	endtask

	// Line closed by CR unless empty
	task automatic send_line(input string s);
		for (int i = 0; i < s.len(); i++)
			send_byte(s[i]);
		if (s.len() > 0)
			send_byte(8'd13);
	endtask

	task automatic wait_tx_idle();
		int idle;
		idle = 0;
		while (idle < IDLE_BITS * BIT_CLKS) begin
			@(posedge clk);
			if (tx === 1'b1 && !dec_busy)
				idle++;
			else
				idle = 0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// tx decoder, samples at mid-bit
	////////////////////////////////////////////////////////////
	initial begin : tx_decoder
		logic [7:0] ch;
		ch = '0;
		wait (reset === 1'b1);
		forever begin
			@(negedge tx);
			dec_busy = 1'b1;
			repeat (BIT_CLKS / 2) @(posedge clk);
			assert (tx === 1'b0) else begin
				$display("Start bit on tx too short at time %0t", $time);
				err_cnt++;
			end
			// LSB first
			for (int k = 0; k < 8; k++) begin
				repeat (BIT_CLKS) @(posedge clk);
				ch[k] = tx;
			end
			repeat (BIT_CLKS) @(posedge clk);
			assert (tx === 1'b1) else begin
				$display("Stop bit missing on tx at time %0t", $time);
				err_cnt++;
			end
			rx_text = $sformatf("%s%c", rx_text, ch);
			dec_busy = 1'b0;
		end
	end

	// Limit from table characters times frame length
	initial begin : watchdog
		wait (wd_time > 0);
		#(wd_time);
		$display("Watchdog expired before all tests finished at time %0t", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin : main
		int d1;
		int d2;
		int d3;
		int d4;
		int bits;
		int errs_before;
		logic [2:0] leds;
		rx <= 1'b1;
		reset <= 1'b0;

		d1 = pick_digit();
		d2 = pick_digit();
		d3 = pick_digit();
		d4 = pick_digit();
		// Idle, then the color words
		add_entry("", "", 3'b111);
		add_entry("red", "", 3'b011);
		add_entry("green", "", 3'b110);
		add_entry("blue", "", 3'b101);
		// Dot prints space then digit
		add_entry($sformatf("%0d .", d1), $sformatf(" %c", digit_char(d1)), 3'b101);
		// Set bit lights the LED
		leds = ~3'(d2);
		add_entry($sformatf("%0d led", d2), "", leds);
		// Misses keep the LEDs
		add_entry("xyz", "?", leds);
		add_entry("ab", "?", leds);
		add_entry("rainbows", "?", leds);
		add_entry($sformatf("%0d . red %0d .", d3, d4),
			$sformatf(" %c %c", digit_char(d3), digit_char(d4)), 3'b011);

		bits = 0;
		for (int i = 0; i < line_tab.size(); i++)
			bits += (line_tab[i].len() + 1) * 20 + IDLE_BITS + text_tab[i].len() * 20;
		wd_time = longint'(bits) * BIT_CLKS * CLK_PERIOD * 2;

		repeat (2) @(posedge clk);
		reset <= 1'b1;

		for (int i = 0; i < line_tab.size(); i++) begin
			errs_before = err_cnt;
			rx_text = "";
			send_line(line_tab[i]);
			wait_tx_idle();
			assert (rx_text == text_tab[i]) else begin
				$display("MISMATCH t=%0t tx text got \"%s\" expected \"%s\"",
					$time, rx_text, text_tab[i]);
				err_cnt++;
			end
			assert ({led_r, led_b, led_g} === led_tab[i]) else begin
				$display("MISMATCH t=%0t leds {r,b,g} got %b expected %b",
					$time, {led_r, led_b, led_g}, led_tab[i]);
				err_cnt++;
			end
			if (err_cnt == errs_before) begin
				pass_cnt++;
				$display("test %0d \"%s\": ok", i, line_tab[i]);
			end else begin
				fail_cnt++;
				$display("test %0d \"%s\": FAILED", i, line_tab[i]);
			end
		end

		$display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== tests/forth_sva.sv ====
////////////////////////////////////////////////////////////
// Protocol checks bound into the token FIFO and the UART
// transmitter
// Each bind ties the inputs it does not use low
////////////////////////////////////////////////////////////
module forth_sva (
	input logic clk,
	input logic reset,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic tx_start,
	input logic tx_busy
);

	// FIFO strobes only when allowed
	fifo_no_overflow: assert property (@(posedge clk) disable iff (!reset) !(push && full))
		else $error("token FIFO pushed while full");
	fifo_no_underflow: assert property (@(posedge clk) disable iff (!reset) !(pop && empty))
		else $error("token FIFO popped while empty");

	// Transmitter takes a byte only when idle
	tx_start_idle: assert property (@(posedge clk) disable iff (!reset) !(tx_start && tx_busy))
		else $error("tx_start while transmitter busy");

endmodule

bind token_fifo forth_sva fifo_checks (
	.clk(clk), .reset(reset), .push(push), .full(full), .pop(pop), .empty(empty),
	.tx_start(1'b0), .tx_busy(1'b0)
);

bind uart_tx forth_sva tx_checks (
	.clk(clk), .reset(reset), .push(1'b0), .full(1'b0), .pop(1'b0), .empty(1'b0),
	.tx_start(tx_start), .tx_busy(tx_busy)
);

// ==== sources.f ====
common/forth_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
outer_interp/outer_interp.sv
src/token_fifo.sv
inner_interp/inner_interp.sv
src/forth_top.sv
tests/forth_tb.sv
tests/forth_sva.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the Forth machine testbench with Verilator and runs it
# Exit status is nonzero when the log holds the fail line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# A broken build or an aborted run also counts as a failure
verilator --binary --assert --top-module forth_tb -f sources.f -o Vforth_tb \
	> sim.log 2>&1 \
	&& ./obj_dir/Vforth_tb >> sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
